//--- fpAddPkg.sv
// Single-precision adder types
package fpAddPkg;

    // Packed IEEE-754 word with sign then exponent then fraction
    typedef logic [31:0] fpWord;

    // Biased exponent
    typedef logic [7:0] expField;

    // Stored fraction without the hidden bit
    typedef logic [22:0] fracField;

    // Fraction with the hidden bit restored
    typedef logic [23:0] mantissa;

    // Guard, round and sticky below the mantissa LSB
    typedef logic [2:0] grsBits;

    // Exponent of infinities and NaNs
    localparam expField expMax = 8'hFF;

    // Handshake control
    typedef enum logic [1:0]
    {
        idle = 2'd0,    // Waiting for req
        busy = 2'd1,    // Pipeline filling
        done = 2'd2     // ack held until req drops
    } ctlState;

endpackage

//--- fpAlign.sv
// Exponent alignment stage
`timescale 1ns/10ps

module fpAlign
(
    input  logic              clk,
    input  logic              reset,
    input  fpAddPkg::fpWord   opA,
    input  fpAddPkg::fpWord   opB,
    input  logic              subtract,
    output fpAddPkg::mantissa bigMant,
    output fpAddPkg::mantissa smallMant,
    output fpAddPkg::expField alignedExp,
    output fpAddPkg::grsBits  grs,
    output logic              signBig,
    output logic              signSmall,
    output fpAddPkg::fpWord   wordA,
    output fpAddPkg::fpWord   wordB
);
    import fpAddPkg::*;

    logic     signA;
    logic     signB;
    expField  expA;
    expField  expB;
    fracField fracA;
    fracField fracB;
    mantissa  mantA;
    mantissa  mantB;
    logic     aIsBig;
    expField  bigExp;
    expField  smallExp;
    mantissa  bigMantC;
    mantissa  smallMantC;
    expField  expDiff;
    logic [4:0]  shiftAmt;
    logic [49:0] shiftWide;     // Mantissa over 26 bits of spill room
    fpWord    adjB;

    // Unpack fields
    always_comb
    begin
        signA = opA[31];
        signB = opB[31] ^ subtract;     // a - b is a + (-b)
        expA  = opA[30:23];
        expB  = opB[30:23];
        fracA = opA[22:0];
        fracB = opB[22:0];
        adjB  = {signB, opB[30:0]};

        // Subnormals read as zero
        mantA = (expA == 8'd0) ? 24'd0 : {1'b1, fracA};
        mantB = (expB == 8'd0) ? 24'd0 : {1'b1, fracB};
    end

    // Order by magnitude and shift the smaller one right
    always_comb
    begin
        aIsBig     = {expA, mantA} >= {expB, mantB};
        bigExp     = aIsBig ? expA  : expB;
        smallExp   = aIsBig ? expB  : expA;
        bigMantC   = aIsBig ? mantA : mantB;
        smallMantC = aIsBig ? mantB : mantA;

        expDiff = bigExp - smallExp;
        // Past 26 every bit ends up in sticky anyway
        shiftAmt  = (expDiff > 8'd26) ? 5'd26 : expDiff[4:0];
        shiftWide = {smallMantC, 26'd0} >> shiftAmt;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            bigMant    <= '0;
            smallMant  <= '0;
            alignedExp <= '0;
            grs        <= '0;
            signBig    <= 1'b0;
            signSmall  <= 1'b0;
            wordA      <= '0;
            wordB      <= '0;
        end
        else
        begin
            bigMant    <= bigMantC;
            smallMant  <= shiftWide[49:26];
            alignedExp <= bigExp;
            grs        <= {shiftWide[25], shiftWide[24], |shiftWide[23:0]};
            signBig    <= aIsBig ? signA : signB;
            signSmall  <= aIsBig ? signB : signA;
            wordA      <= opA;
            wordB      <= adjB;     // Carries the flipped sign when subtracting
        end
    end

endmodule

//--- fpMantissaAdd.sv
// Mantissa addition stage
`timescale 1ns/10ps

module fpMantissaAdd
(
    input  logic              clk,
    input  logic              reset,
    input  fpAddPkg::mantissa bigMant,
    input  fpAddPkg::mantissa smallMant,
    input  fpAddPkg::expField alignedExp,
    input  fpAddPkg::grsBits  grs,
    input  logic              signBig,
    input  logic              signSmall,
    output fpAddPkg::mantissa sumMant,
    output logic              carryOut,
    output logic              sumSign,
    output fpAddPkg::grsBits  sumGrs,
    output fpAddPkg::expField sumExp
);
    import fpAddPkg::*;

    logic [26:0] bigExt;        // Mantissa with three extra low bits
    logic [26:0] smallExt;
    logic [27:0] total;
    logic        signC;

    always_comb
    begin
        bigExt   = {bigMant, 3'b000};
        smallExt = {smallMant, grs};

        // Big is never below small so the difference stays positive
        if (signBig == signSmall)
            total = {1'b0, bigExt} + {1'b0, smallExt};
        else
            total = {1'b0, bigExt} - {1'b0, smallExt};

        // Exact zero is +0 unless both inputs were negative
        if (total == 28'd0)
            signC = signBig & signSmall;
        else
            signC = signBig;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            sumMant  <= '0;
            carryOut <= 1'b0;
            sumSign  <= 1'b0;
            sumGrs   <= '0;
            sumExp   <= '0;
        end
        else
        begin
            sumMant  <= total[26:3];
            carryOut <= total[27];
            sumSign  <= signC;
            sumGrs   <= total[2:0];
            sumExp   <= alignedExp;    // Adjusted later in normalize
        end
    end

endmodule

//--- fpNormalize.sv
// Normalize and round stage
`timescale 1ns/10ps

module fpNormalize
(
    input  logic              clk,
    input  logic              reset,
    input  fpAddPkg::mantissa sumMant,
    input  logic              carryOut,
    input  logic              sumSign,
    input  fpAddPkg::grsBits  sumGrs,
    input  fpAddPkg::expField sumExp,
    input  fpAddPkg::fpWord   wordA,
    input  fpAddPkg::fpWord   wordB,
    output fpAddPkg::fpWord   result
);
    import fpAddPkg::*;

    localparam fpWord defaultNan = 32'h7FFF_FFFF;   // Inf minus inf

    logic        aNan;
    logic        bNan;
    logic        aInf;
    logic        bInf;
    logic [4:0]  lzc;
    logic [26:0] shifted;
    mantissa     normMant;
    grsBits      normGrs;
    logic [8:0]  normExp;       // Extra bit catches overflow
    logic [8:0]  finalExp;
    logic        isZero;
    logic        roundUp;
    logic [24:0] rounded;
    fracField    roundFrac;
    fpWord       nextResult;

    // Leading zeros of a 24-bit mantissa or 24 when all clear
    function automatic logic [4:0] countZeros(input mantissa value);
        logic [4:0] count;
        count = 5'd24;
        for (int i = 0; i < 24; i++)
        begin
            if (value[i])
                count = 5'(23 - i);     // Highest set bit wins
        end
        return count;
    endfunction

    // Special operand classes
    always_comb
    begin
        aNan = (wordA[30:23] == expMax) && (fracField'(wordA[22:0]) != '0);
        bNan = (wordB[30:23] == expMax) && (fracField'(wordB[22:0]) != '0);
        aInf = (wordA[30:23] == expMax) && (fracField'(wordA[22:0]) == '0);
        bInf = (wordB[30:23] == expMax) && (fracField'(wordB[22:0]) == '0);
    end

    always_comb
    begin
        lzc      = countZeros(sumMant);
        shifted  = {sumMant, sumGrs} << lzc;
        normMant = shifted[26:3];
        normGrs  = shifted[2:0];
        normExp  = {1'b0, sumExp} - {4'd0, lzc};
        isZero   = 1'b0;

        if (carryOut)
        begin
            // One bit right with the old LSB moving into guard
            normMant = {1'b1, sumMant[23:1]};
            normGrs  = {sumMant[0], sumGrs[2], |sumGrs[1:0]};
            normExp  = {1'b0, sumExp} + 9'd1;
        end
        else if ((lzc == 5'd24) || ({3'd0, lzc} >= sumExp))
            isZero = 1'b1;     // Cancelled or would land below exponent 1

        // Round to nearest with ties to even
        roundUp = normGrs[2] & (normGrs[1] | normGrs[0] | normMant[0]);
        rounded = {1'b0, normMant} + {24'd0, roundUp};

        if (rounded[24])
        begin
            roundFrac = rounded[23:1];
            finalExp  = normExp + 9'd1;     // Rounding carried out of the mantissa
        end
        else
        begin
            roundFrac = rounded[22:0];
            finalExp  = normExp;
        end

        // NaN first, then infinities, then the computed value
        if (aNan)
            nextResult = wordA;
        else if (bNan)
            nextResult = wordB;
        else if (aInf && bInf)
            nextResult = (wordA[31] == wordB[31]) ? wordA : defaultNan;
        else if (aInf)
            nextResult = wordA;
        else if (bInf)
            nextResult = wordB;
        else if (isZero)
            nextResult = {sumSign, 31'd0};
        else if (finalExp >= 9'd255)
            nextResult = {sumSign, expMax, 23'd0};     // Overflow to infinity
        else
            nextResult = {sumSign, finalExp[7:0], roundFrac};
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            result <= '0;
        else
            result <= nextResult;
    end

endmodule

//--- fpAddControl.sv
// Handshake control FSM
`timescale 1ns/10ps

module fpAddControl
(
    input  logic clk,
    input  logic reset,
    input  logic req,
    output logic ack
);
    import fpAddPkg::*;

    ctlState    state;
    logic [1:0] busyCount;      // Cycles spent in busy

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state     <= idle;
            busyCount <= 2'd0;
        end
        else
        begin
            case (state)
                idle:
                begin
                    busyCount <= 2'd0;
                    if (req)
                        state <= busy;  // Operands are already in the align stage
                end

                busy:
                begin
                    busyCount <= busyCount + 2'd1;
                    // Third busy cycle ends here
                    if (busyCount == 2'd2)
                        state <= done;
                end

                done:
                begin
                    // Held until the requester drops req
                    if (!req)
                        state <= idle;
                end

                default:
                begin
                    state <= idle;
                end
            endcase
        end
    end

    assign ack = (state == done);

endmodule

//--- fpAdder.sv
// Floating-point adder top level
`timescale 1ns/10ps

module fpAdder
(
    input  logic            clk,
    input  logic            reset,
    input  logic            req,
    input  logic            subtract,
    input  fpAddPkg::fpWord opA,
    input  fpAddPkg::fpWord opB,
    output logic            ack,
    output fpAddPkg::fpWord result
);
    import fpAddPkg::*;

    mantissa bigMant;
    mantissa smallMant;
    expField alignedExp;
    grsBits  grs;
    logic    signBig;
    logic    signSmall;
    fpWord   wordA;
    fpWord   wordB;

    mantissa sumMant;
    logic    carryOut;
    logic    sumSign;
    grsBits  sumGrs;
    expField sumExp;

    fpAddControl control (.clk(clk), .reset(reset), .req(req), .ack(ack));

    fpAlign align (
        .clk(clk), .reset(reset), .opA(opA), .opB(opB), .subtract(subtract),
        .bigMant(bigMant), .smallMant(smallMant), .alignedExp(alignedExp), .grs(grs),
        .signBig(signBig), .signSmall(signSmall), .wordA(wordA), .wordB(wordB)
    );

    fpMantissaAdd mantAdd (
        .clk(clk), .reset(reset), .bigMant(bigMant), .smallMant(smallMant),
        .alignedExp(alignedExp), .grs(grs), .signBig(signBig), .signSmall(signSmall),
        .sumMant(sumMant), .carryOut(carryOut), .sumSign(sumSign), .sumGrs(sumGrs),
        .sumExp(sumExp)
    );

    fpNormalize normalize (
        .clk(clk), .reset(reset), .sumMant(sumMant), .carryOut(carryOut),
        .sumSign(sumSign), .sumGrs(sumGrs), .sumExp(sumExp),
        .wordA(wordA), .wordB(wordB), .result(result)
    );

endmodule

//--- fpAdder_props.sv
// Adder handshake assertions
`timescale 1ns/10ps

module fpAdderProps
(
    input logic        clk,
    input logic        reset,
    input logic        req,
    input logic        ack,
    input logic [31:0] result
);

    ackAfterReset: assert property (@(posedge clk) reset |=> !ack)
        else $error("ack high right after reset");

    // ack stays low through busy after req rises
    ackQuiet: assert property (@(posedge clk) disable iff (reset)
        (req && !$past(req) && !ack) |=> !ack ##1 !ack ##1 !ack)
        else $error("ack rose early");

    ackDelay: assert property (@(posedge clk) disable iff (reset)
        (req && !$past(req) && !ack) |-> ##4 ack)
        else $error("ack not raised 3 cycles after req");

    ackDrop: assert property (@(posedge clk) disable iff (reset) (ack && !req) |=> !ack)
        else $error("ack held after req dropped");

    resultHold: assert property (@(posedge clk) disable iff (reset)
        (ack && $past(ack)) |-> $stable(result))
        else $error("result changed while ack high");

endmodule

//--- fpAdderTb.sv
// Floating-point adder testbench
`timescale 1ns/10ps

module fpAdderTb;

    localparam int directedOps = 10;
    localparam int randomPairs = 150;
    localparam int totalOps    = directedOps + 3 * randomPairs;
    localparam int cycleLimit  = 40 * totalOps + 100;

    logic        clk;
    logic        reset;
    logic        req;
    logic        subtract;
    logic [31:0] opA;
    logic [31:0] opB;
    logic        ack;
    logic [31:0] result;

    logic [31:0] lfsr;
    logic [31:0] expQ[$];
    int          cycleCount;
    int          valueErrors;
    int          timingErrors;
    int          opCount;
    int          ackCount;

    // Checker state
    logic        inFlight;
    logic        ackSeen;
    int          reqEdge;
    logic [31:0] heldResult;
    logic [31:0] expected;

    fpAdder uut
    (
        .clk(clk), .reset(reset), .req(req), .subtract(subtract),
        .opA(opA), .opB(opB), .ack(ack), .result(result)
    );

    bind fpAdder fpAdderProps props
    (
        .clk(clk), .reset(reset), .req(req), .ack(ack), .result(result)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h8020_0003;
        else
            return s >> 1;
    endfunction

    task automatic takeBits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsrNext(lfsr);
        end
    endtask

    // Expected sum from an exact wide integer and round to nearest even
    function automatic logic [31:0] refAdd(input logic [31:0] a, input logic [31:0] b,
                                           input logic sub);
        logic [31:0]  nb;
        logic         aNan;
        logic         bNan;
        logic         aInf;
        logic         bInf;
        logic [299:0] magA;
        logic [299:0] magB;
        logic [299:0] mag;
        logic [299:0] top;
        logic         sign;
        logic [24:0]  m;
        logic         g;
        logic         st;
        int           p;
        int           e;
        nb   = {b[31] ^ sub, b[30:0]};
        aNan = (a[30:23] == 8'hFF) && (a[22:0] != 23'd0);
        bNan = (nb[30:23] == 8'hFF) && (nb[22:0] != 23'd0);
        aInf = (a[30:23] == 8'hFF) && (a[22:0] == 23'd0);
        bInf = (nb[30:23] == 8'hFF) && (nb[22:0] == 23'd0);
        if (aNan)
            return a;
        if (bNan)
            return nb;
        if (aInf && bInf)
            return (a[31] == nb[31]) ? a : 32'h7FFF_FFFF;
        if (aInf)
            return a;
        if (bInf)
            return nb;

        // Value is mag times 2^-149 and subnormals count as zero
        magA = '0;
        magB = '0;
        if (a[30:23] != 8'd0)
            magA = {276'd0, 1'b1, a[22:0]} << (a[30:23] - 8'd1);
        if (nb[30:23] != 8'd0)
            magB = {276'd0, 1'b1, nb[22:0]} << (nb[30:23] - 8'd1);

        if (a[31] == nb[31])
        begin
            mag  = magA + magB;
            sign = a[31];
        end
        else if (magA >= magB)
        begin
            mag  = magA - magB;
            sign = a[31];
        end
        else
        begin
            mag  = magB - magA;
            sign = nb[31];
        end
        if (mag == '0)
            return {a[31] & nb[31], 31'd0};

        p = 0;
        for (int i = 0; i < 300; i++)
        begin
            if (mag[i])
                p = i;
        end
        e = p - 22;
        if (e < 1)
            return {sign, 31'd0};     // Below the normal range

        top = mag >> (p - 23);
        m   = {1'b0, top[23:0]};
        g   = (p >= 24) ? mag[p - 24] : 1'b0;
        st  = 1'b0;
        for (int i = 0; i < p - 24; i++)
            st = st | mag[i];
        if (g && (st || m[0]))
            m = m + 25'd1;
        if (m[24])
        begin
            m = m >> 1;
            e = e + 1;
        end
        if (e >= 255)
            return {sign, 8'hFF, 23'd0};
        return {sign, e[7:0], m[22:0]};
    endfunction

    // Random operand with a biased exponent class
    task automatic makeOperand(output logic [31:0] w);
        logic [31:0] s;
        logic [31:0] cls;
        logic [31:0] e;
        logic [31:0] f;
        logic [31:0] pick;
        takeBits(1, s);
        takeBits(3, cls);
        takeBits(23, f);
        case (cls[2:0])
            3'd0: e = 32'd0;
            3'd1:
            begin
                e = 32'd255;
                takeBits(1, pick);
                if (!pick[0])
                    f = 32'd0;  // Infinity
            end
            3'd2:
            begin
                takeBits(2, pick);
                e = 32'd251 + pick;
            end
            3'd3:
            begin
                takeBits(2, pick);
                e = 32'd1 + pick;
            end
            default:
            begin
                takeBits(8, e);
                if (e[7:0] == 8'd0)
                    e = 32'd1;
                if (e[7:0] == 8'd255)
                    e = 32'd254;
            end
        endcase
        w = {s[0], e[7:0], f[22:0]};
    endtask

    // Partner close to a so that differences cancel heavily
    task automatic makeNear(input logic [31:0] a, output logic [31:0] w);
        logic [31:0] s;
        logic [31:0] d;
        logic [31:0] f;
        logic [7:0]  e;
        takeBits(1, s);
        takeBits(1, d);
        takeBits(5, f);
        e = a[30:23];
        if (d[0] && (e != 8'd0) && (e < 8'd254))
            e = e + 8'd1;
        w = {s[0], e, a[22:0] ^ {18'd0, f[4:0]}};
    endtask

    task automatic runOp(input logic [31:0] a, input logic [31:0] b, input logic sub,
                         output logic [31:0] got);
        logic [31:0] hold;
        @(posedge clk);
        opA      <= a;
        opB      <= b;
        subtract <= sub;
        req      <= 1'b1;
        expQ.push_back(refAdd(a, b, sub));
        opCount++;
        do @(posedge clk); while (!ack);
        got = result;
        takeBits(2, hold);
        repeat (hold[1:0]) @(posedge clk);     // Back-pressure
        req <= 1'b0;
        do @(posedge clk); while (ack);
    endtask

    always @(posedge clk)
    begin
        if (reset)
            cycleCount <= 0;
        else
            cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit)
        begin
            $display("Timeout: no handshake completed within %0d cycles", cycleLimit);
            $display("Simulation failed");
            $finish;
        end
    end

    // Compare each ack against the queued reference value
    always @(posedge clk)
    begin
        if (reset)
        begin
            inFlight = 1'b0;
            ackSeen  = 1'b0;
        end
        else
        begin
            if (ack && !ackSeen)
            begin
                ackSeen = 1'b1;
                ackCount++;
                heldResult = result;
                if (!inFlight || (expQ.size() == 0))
                begin
                    $display("Unexpected ack at %0t with no operation pending", $time);
                    timingErrors++;
                end
                else
                begin
                    expected = expQ.pop_front();
                    if (cycleCount - reqEdge != 4)     // ack seen one edge after it rises
                    begin
                        $display("ERR %0t: ack after %0d cycles", $time, cycleCount - reqEdge - 1);
                        timingErrors++;
                    end
                    if (result !== expected)
                    begin
                        $display("ERR %0t: result %h expected %h", $time, result, expected);
                        valueErrors++;
                    end
                end
            end
            else if (ack && (result !== heldResult))
            begin
                $display("ERR %0t: result changed while ack high", $time);
                timingErrors++;
            end
            else if (!ack && ackSeen)
            begin
                ackSeen  = 1'b0;
                inFlight = 1'b0;
            end
            if (req && !inFlight && !ack)
            begin
                inFlight = 1'b1;
                reqEdge  = cycleCount;
            end
        end
    end

    initial
    begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] pick;
        logic [31:0] addRes;
        logic [31:0] subRes;
        logic [31:0] negRes;
        reset        = 1'b1;
        req          = 1'b0;
        subtract     = 1'b0;
        opA          = '0;
        opB          = '0;
        lfsr         = 32'd9;
        valueErrors  = 0;
        timingErrors = 0;
        opCount      = 0;
        ackCount     = 0;

        repeat (2) @(posedge clk);
        reset <= 1'b0;

        runOp(32'h3F80_0000, 32'h3380_0000, 1'b0, addRes);     // Tie to even
        runOp(32'h3F80_0001, 32'h3380_0000, 1'b0, addRes);     // Tie rounds up
        runOp(32'h3FFF_FFFF, 32'h3380_0000, 1'b0, addRes);     // Rounding carry
        runOp(32'h7F7F_FFFF, 32'h7F7F_FFFF, 1'b0, addRes);     // Overflow
        runOp(32'h0080_0001, 32'h0080_0000, 1'b1, addRes);     // Underflow
        runOp(32'h4049_0FDB, 32'h4049_0FDB, 1'b1, addRes);     // Exact cancel
        runOp(32'h7F80_0000, 32'hFF80_0000, 1'b0, addRes);     // Opposite infinities
        runOp(32'hFF80_0000, 32'h7F80_0000, 1'b1, addRes);     // Equal infinities
        runOp(32'h3F80_0000, 32'h7FC0_0001, 1'b1, addRes);     // NaN in B
        runOp(32'h4B00_0001, 32'h4AFF_FFFE, 1'b1, addRes);     // Deep cancel

        for (int i = 0; i < randomPairs; i++)
        begin
            makeOperand(a);
            takeBits(1, pick);
            if (pick[0])
                makeNear(a, b);
            else
                makeOperand(b);
            runOp(a, b, 1'b0, addRes);
            runOp(a, b, 1'b1, subRes);
            runOp(a, {~b[31], b[30:0]}, 1'b0, negRes);
            if (subRes !== negRes)
            begin
                $display("ERR %0t: a - b gave %h but a + (-b) gave %h", $time, subRes, negRes);
                valueErrors++;
            end
        end

        repeat (2) @(posedge clk);
        if (ackCount != opCount)
        begin
            $display("Saw %0d acks for %0d operations", ackCount, opCount);
            timingErrors++;
        end
        $display("Errors: %0d value, %0d timing", valueErrors, timingErrors);
        if (valueErrors + timingErrors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

//--- flist.f
fpAddPkg.sv
fpAlign.sv
fpMantissaAdd.sv
fpNormalize.sv
fpAddControl.sv
fpAdder.sv
fpAdder_props.sv
fpAdderTb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass message in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f flist.f --top-module fpAdderTb -o simv &&
./obj_dir/simv | tee /dev/stderr | grep -q "^Simulation completed successfully$" &&
echo "PASS" || {
    echo "FAIL"
    exit 1
}
